/* hdl/isa_pkg.sv */
// instruction set definitions
package isa_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////
    localparam int WORD_W    = 16;
    localparam int REG_IDX_W = 3;
    localparam int OPCODE_W  = 5;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // opcode lives in instr[15:11], unlisted values are illegal
    typedef enum logic [OPCODE_W-1:0] {
        OP_HALT = 5'b00000,
        OP_J    = 5'b00100,
        OP_ADDI = 5'b01000,
        OP_BEQZ = 5'b01100,
        OP_BNEZ = 5'b01101,
        OP_ST   = 5'b10000,
        OP_LD   = 5'b10001,
        OP_LBI  = 5'b11000,
        OP_ADD  = 5'b11001,
        OP_SUB  = 5'b11010,
        OP_AND  = 5'b11011,
        OP_XOR  = 5'b11100
    } opcode_t;

    ////////////////////////////////////////////////////////////
    // field positions
    ////////////////////////////////////////////////////////////
    localparam int OP_LSB = 11;
    localparam int RS_LSB = 8;
    localparam int RT_LSB = 5;
    localparam int RD_LSB = 2;

    // immediates all start at bit 0
    localparam int IMM5_W   = 5;
    localparam int IMM8_W   = 8;
    localparam int DISP11_W = 11;

    // destinations: r-type writes rd, addi and ld write rt, lbi writes rs
    // st stores rt at rs + imm5

endpackage

/* hdl/ctrl_pkg.sv */
// control word and stage selects
package ctrl_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_t;

    // second alu operand
    typedef enum logic {
        SRC_B_REG,
        SRC_B_IMM
    } src_b_t;

    typedef enum logic {
        WB_ALU,
        WB_MEM
    } wb_sel_t;

    typedef enum logic [1:0] {
        PC_SEQ,
        PC_BRANCH,
        PC_JUMP,
        PC_HOLD
    } pc_sel_t;

    typedef struct packed {
        alu_op_t alu_op;
        src_b_t  src_b;
        wb_sel_t wb_sel;
        logic    reg_we;
        logic    mem_we;
        logic    mem_re;
        logic    is_branch;
        logic    branch_on_zero;
        logic    is_jump;
        logic    halt;
        logic    illegal;
    } ctrl_t;

    // one finished instruction, seen by the testbench
    typedef struct packed {
        logic              valid;
        isa_pkg::word_t    pc;
        logic              reg_we;
        isa_pkg::reg_idx_t wr_reg;
        isa_pkg::word_t    wr_data;
        logic              mem_we;
        isa_pkg::word_t    mem_addr;
        isa_pkg::word_t    mem_wdata;
    } retire_t;

endpackage

/* hdl/fetch.sv */
// instruction fetch
`timescale 1ns/1ps

module fetch #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           imem_we,
    input  isa_pkg::word_t imem_addr,
    input  isa_pkg::word_t imem_data,
    input  isa_pkg::word_t next_pc,
    input  logic           stop,
    output isa_pkg::word_t pc,
    output isa_pkg::word_t pc_plus,
    output isa_pkg::word_t instr,
    output logic           halted
);
    import isa_pkg::*;

    localparam int IAW = $clog2(IMEM_DEPTH);

    word_t imem [IMEM_DEPTH];

    ////////////////////////////////////////////////////////////
    // program load, only while the core sits in reset
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (imem_we && !rst_n) begin
            imem[imem_addr[IAW-1:0]] <= imem_data;
        end
    end

    assign instr   = imem[pc[IAW-1:0]];
    assign pc_plus = pc + word_t'(1);

    ////////////////////////////////////////////////////////////
    // pc and halt flag
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc     <= '0;
            halted <= 1'b0;
        end else begin
            // frozen once halted
            if (!halted) begin
                pc <= next_pc;
            end
            if (stop) begin
                halted <= 1'b1;
            end
        end
    end

    // loading a running core would change code under execution
    a_no_load_when_running: assert property (@(posedge clk) rst_n |-> !imem_we);

endmodule

/* hdl/reg_file.sv */
// register file
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  isa_pkg::reg_idx_t rd_a,
    input  isa_pkg::reg_idx_t rd_b,
    input  logic              we,
    input  isa_pkg::reg_idx_t wr_reg,
    input  isa_pkg::word_t    wr_data,
    output isa_pkg::word_t    data_a,
    output isa_pkg::word_t    data_b
);
    import isa_pkg::*;

    localparam int NUM_REGS = 2 ** REG_IDX_W;

    word_t regs [NUM_REGS];

    // r0 is a normal register here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr_reg] <= wr_data;
        end
    end

    // reads see the old value during a same-cycle write
    assign data_a = regs[rd_a];
    assign data_b = regs[rd_b];

endmodule

/* hdl/decode.sv */
// instruction decode
`timescale 1ns/1ps

module decode (
    input  logic              clk,
    input  logic              rst_n,
    input  isa_pkg::word_t    instr,
    input  logic              halted,
    input  isa_pkg::word_t    wb_data,
    output ctrl_pkg::ctrl_t   ctrl,
    output isa_pkg::word_t    rs_data,
    output isa_pkg::word_t    rt_data,
    output isa_pkg::word_t    imm,
    output isa_pkg::reg_idx_t wr_reg
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    opcode_t  opcode;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    word_t    imm5_ext;
    word_t    imm8_ext;
    word_t    disp11_ext;
    ctrl_t    c;

    assign opcode = opcode_t'(instr[OP_LSB +: OPCODE_W]);
    assign rs     = instr[RS_LSB +: REG_IDX_W];
    assign rt     = instr[RT_LSB +: REG_IDX_W];
    assign rd     = instr[RD_LSB +: REG_IDX_W];

    // sign extension
    assign imm5_ext   = {{(WORD_W-IMM5_W){instr[IMM5_W-1]}}, instr[IMM5_W-1:0]};
    assign imm8_ext   = {{(WORD_W-IMM8_W){instr[IMM8_W-1]}}, instr[IMM8_W-1:0]};
    assign disp11_ext = {{(WORD_W-DISP11_W){instr[DISP11_W-1]}}, instr[DISP11_W-1:0]};

    ////////////////////////////////////////////////////////////
    // control decoder
    ////////////////////////////////////////////////////////////
    always_comb begin
        c        = '0;
        c.alu_op = ALU_ADD;
        c.src_b  = SRC_B_REG;
        c.wb_sel = WB_ALU;
        imm      = imm5_ext;
        wr_reg   = rd;
        case (opcode)
            OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
                c.reg_we = 1'b1;
                case (opcode)
                    OP_SUB:  c.alu_op = ALU_SUB;
                    OP_AND:  c.alu_op = ALU_AND;
                    OP_XOR:  c.alu_op = ALU_XOR;
                    default: c.alu_op = ALU_ADD;
                endcase
            end
            OP_ADDI: begin
                c.src_b  = SRC_B_IMM;
                c.reg_we = 1'b1;
                wr_reg   = rt;
            end
            OP_LBI: begin
                c.alu_op = ALU_PASS_B;
                c.src_b  = SRC_B_IMM;
                c.reg_we = 1'b1;
                imm      = imm8_ext;
                wr_reg   = rs;
            end
            OP_LD: begin
                c.src_b  = SRC_B_IMM;
                c.wb_sel = WB_MEM;
                c.reg_we = 1'b1;
                c.mem_re = 1'b1;
                wr_reg   = rt;
            end
            OP_ST: begin
                c.src_b  = SRC_B_IMM;
                c.mem_we = 1'b1;
            end
            OP_BEQZ, OP_BNEZ: begin
                c.is_branch      = 1'b1;
                c.branch_on_zero = (opcode == OP_BEQZ);
                imm              = imm8_ext;
            end
            OP_J: begin
                c.is_jump = 1'b1;
                imm       = disp11_ext;
            end
            OP_HALT: c.halt = 1'b1;
            default: c.illegal = 1'b1;
        endcase
        // no register writes once the core has stopped
        c.reg_we = c.reg_we & ~halted;
        ctrl     = c;
    end

    reg_file reg_file_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_a    (rs),
        .rd_b    (rt),
        .we      (ctrl.reg_we),
        .wr_reg  (wr_reg),
        .wr_data (wb_data),
        .data_a  (rs_data),
        .data_b  (rt_data)
    );

    a_we_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(ctrl.reg_we && ctrl.mem_we)
    );

endmodule

/* hdl/execute.sv */
// alu and branch resolution
`timescale 1ns/1ps

module execute (
    input  ctrl_pkg::ctrl_t ctrl,
    input  isa_pkg::word_t  rs_data,
    input  isa_pkg::word_t  rt_data,
    input  isa_pkg::word_t  imm,
    input  isa_pkg::word_t  pc_plus,
    output isa_pkg::word_t  alu_out,
    output logic            branch_taken,
    output isa_pkg::word_t  branch_target,
    output isa_pkg::word_t  jump_target
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    word_t alu_b;
    word_t branch_disp;
    word_t jump_disp;
    logic  rs_zero;

    ////////////////////////////////////////////////////////////
    // alu
    ////////////////////////////////////////////////////////////
    assign alu_b = (ctrl.src_b == SRC_B_IMM) ? imm : rt_data;

    // 16-bit wraparound, no flags
    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    alu_out = rs_data + alu_b;
            ALU_SUB:    alu_out = rs_data - alu_b;
            ALU_AND:    alu_out = rs_data & alu_b;
            ALU_XOR:    alu_out = rs_data ^ alu_b;
            ALU_PASS_B: alu_out = alu_b;
            default:    alu_out = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // branch condition and targets
    ////////////////////////////////////////////////////////////
    assign rs_zero      = (rs_data == '0);
    assign branch_taken = ctrl.is_branch && (rs_zero == ctrl.branch_on_zero);

    // branch displacement is 8 bits, jump displacement 11
    assign branch_disp = {{(WORD_W-IMM8_W){imm[IMM8_W-1]}}, imm[IMM8_W-1:0]};
    assign jump_disp   = {{(WORD_W-DISP11_W){imm[DISP11_W-1]}}, imm[DISP11_W-1:0]};

    assign branch_target = pc_plus + branch_disp;
    assign jump_target   = pc_plus + jump_disp;

endmodule

/* hdl/memory.sv */
// data memory, next pc and write-back select
`timescale 1ns/1ps

module memory #(
    parameter int DMEM_DEPTH = 256
) (
    input  logic            clk,
    input  logic            rst_n,
    input  ctrl_pkg::ctrl_t ctrl,
    input  logic            halted,
    input  isa_pkg::word_t  alu_out,
    input  isa_pkg::word_t  rt_data,
    input  isa_pkg::word_t  pc_plus,
    input  logic            branch_taken,
    input  isa_pkg::word_t  branch_target,
    input  isa_pkg::word_t  jump_target,
    output isa_pkg::word_t  wb_data,
    output isa_pkg::word_t  next_pc
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    localparam int DAW = $clog2(DMEM_DEPTH);

    word_t   dmem [DMEM_DEPTH];
    word_t   rdata;
    logic    wr_en;
    pc_sel_t pc_sel;

    assign wr_en = ctrl.mem_we & ~halted;

    ////////////////////////////////////////////////////////////
    // data memory, word addressed
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (wr_en) begin
            dmem[alu_out[DAW-1:0]] <= rt_data;
        end
    end

    assign rdata   = ctrl.mem_re ? dmem[alu_out[DAW-1:0]] : '0;
    assign wb_data = (ctrl.wb_sel == WB_MEM) ? rdata : alu_out;

    ////////////////////////////////////////////////////////////
    // next pc
    ////////////////////////////////////////////////////////////
    always_comb begin
        if (halted || ctrl.halt || ctrl.illegal) begin
            pc_sel = PC_HOLD;
        end else if (ctrl.is_jump) begin
            pc_sel = PC_JUMP;
        end else if (branch_taken) begin
            pc_sel = PC_BRANCH;
        end else begin
            pc_sel = PC_SEQ;
        end
    end

    always_comb begin
        case (pc_sel)
            PC_BRANCH: next_pc = branch_target;
            PC_JUMP:   next_pc = jump_target;
            PC_HOLD:   next_pc = pc_plus - word_t'(1);
            default:   next_pc = pc_plus;
        endcase
    end

    // upper address bits are dropped by the array index
    a_addr_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        ((ctrl.mem_we || ctrl.mem_re) && !halted) |-> (alu_out < DMEM_DEPTH)
    );

endmodule

/* hdl/proc.sv */
// single-cycle processor top level
`timescale 1ns/1ps

module proc #(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 256
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              imem_we,
    input  isa_pkg::word_t    imem_addr,
    input  isa_pkg::word_t    imem_data,
    output ctrl_pkg::retire_t retire,
    output logic              err
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    ////////////////////////////////////////////////////////////
    // stage signals
    ////////////////////////////////////////////////////////////
    word_t    pc;
    word_t    pc_plus;
    word_t    instr;
    word_t    next_pc;
    logic     halted;
    logic     stop;
    ctrl_t    ctrl;
    word_t    rs_data;
    word_t    rt_data;
    word_t    imm;
    reg_idx_t wr_reg;
    word_t    alu_out;
    logic     branch_taken;
    word_t    branch_target;
    word_t    jump_target;
    word_t    wb_data;
    logic     valid;
    logic     err_q;

    assign stop = ctrl.halt | ctrl.illegal;

    fetch #(.IMEM_DEPTH(IMEM_DEPTH)) fetch_i (
        .clk(clk), .rst_n(rst_n),
        .imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
        .next_pc(next_pc), .stop(stop),
        .pc(pc), .pc_plus(pc_plus), .instr(instr), .halted(halted)
    );

    decode decode_i (
        .clk(clk), .rst_n(rst_n), .instr(instr), .halted(halted), .wb_data(wb_data),
        .ctrl(ctrl), .rs_data(rs_data), .rt_data(rt_data), .imm(imm), .wr_reg(wr_reg)
    );

    execute execute_i (
        .ctrl(ctrl), .rs_data(rs_data), .rt_data(rt_data), .imm(imm), .pc_plus(pc_plus),
        .alu_out(alu_out), .branch_taken(branch_taken),
        .branch_target(branch_target), .jump_target(jump_target)
    );

    memory #(.DMEM_DEPTH(DMEM_DEPTH)) memory_i (
        .clk(clk), .rst_n(rst_n), .ctrl(ctrl), .halted(halted),
        .alu_out(alu_out), .rt_data(rt_data), .pc_plus(pc_plus),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .jump_target(jump_target), .wb_data(wb_data), .next_pc(next_pc)
    );

    ////////////////////////////////////////////////////////////
    // retirement and error
    ////////////////////////////////////////////////////////////
    // the instruction at pc retires on every running cycle
    assign valid = rst_n & ~halted;

    assign retire.valid     = valid;
    assign retire.pc        = pc;
    assign retire.reg_we    = ctrl.reg_we & valid;
    assign retire.wr_reg    = wr_reg;
    assign retire.wr_data   = wb_data;
    assign retire.mem_we    = ctrl.mem_we & valid;
    assign retire.mem_addr  = alu_out;
    assign retire.mem_wdata = rt_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_q <= 1'b0;
        end else if (ctrl.illegal && !halted) begin
            err_q <= 1'b1;
        end
    end

    // high in the illegal cycle itself, then held by err_q
    assign err = err_q | (ctrl.illegal & valid);

endmodule

/* include/tb_asm.svh */
// instruction encoders
`ifndef TB_ASM_SVH
`define TB_ASM_SVH

// rd = rs op rt
function automatic isa_pkg::word_t asm_rtype(input isa_pkg::opcode_t op,
                                             input isa_pkg::reg_idx_t rd,
                                             input isa_pkg::reg_idx_t rs,
                                             input isa_pkg::reg_idx_t rt);
    return {op, rs, rt, rd, 2'b00};
endfunction

// rt = rs + sext(imm5)
function automatic isa_pkg::word_t asm_addi(input isa_pkg::reg_idx_t rt,
                                            input isa_pkg::reg_idx_t rs,
                                            input logic [4:0] imm5);
    return {isa_pkg::OP_ADDI, rs, rt, imm5};
endfunction

function automatic isa_pkg::word_t asm_lbi(input isa_pkg::reg_idx_t rs,
                                           input logic [7:0] imm8);
    return {isa_pkg::OP_LBI, rs, imm8};
endfunction

// rt = mem[rs + sext(imm5)]
function automatic isa_pkg::word_t asm_ld(input isa_pkg::reg_idx_t rt,
                                          input isa_pkg::reg_idx_t rs,
                                          input logic [4:0] imm5);
    return {isa_pkg::OP_LD, rs, rt, imm5};
endfunction

// mem[rs + sext(imm5)] = rt
function automatic isa_pkg::word_t asm_st(input isa_pkg::reg_idx_t rt,
                                          input isa_pkg::reg_idx_t rs,
                                          input logic [4:0] imm5);
    return {isa_pkg::OP_ST, rs, rt, imm5};
endfunction

// beqz when on_zero is set, bnez otherwise
function automatic isa_pkg::word_t asm_branch(input logic on_zero,
                                              input isa_pkg::reg_idx_t rs,
                                              input logic [7:0] disp8);
    return {(on_zero ? isa_pkg::OP_BEQZ : isa_pkg::OP_BNEZ), rs, disp8};
endfunction

function automatic isa_pkg::word_t asm_j(input logic [10:0] disp11);
    return {isa_pkg::OP_J, disp11};
endfunction

function automatic isa_pkg::word_t asm_halt();
    return {isa_pkg::OP_HALT, 11'd0};
endfunction

// opcode 5'b11111 is left undefined
function automatic isa_pkg::word_t asm_undef();
    return {5'b11111, 11'd0};
endfunction

`endif

/* verif/proc_tb.sv */
// processor testbench
`timescale 1ns/1ps

module proc_tb;
    import isa_pkg::*;
    import ctrl_pkg::*;

    `include "tb_asm.svh"

    localparam int IMEM_DEPTH   = 256;
    localparam int DMEM_DEPTH   = 256;
    localparam int RESET_CYCLES = 10;
    localparam int RAND_LEN     = 60;
    localparam int DRAIN_CYCLES = 10;
    localparam logic [31:0] SEED = 32'hac58_2bdc;

    logic    clk;
    logic    rst_n;
    logic    imem_we;
    word_t   imem_addr;
    word_t   imem_data;
    retire_t retire;
    logic    err;

    // reference model state
    word_t   m_regs [8];
    word_t   m_dmem [DMEM_DEPTH];
    word_t   m_imem [IMEM_DEPTH];
    word_t   m_pc;
    logic    m_halted;
    logic    m_err;
    retire_t exp;
    word_t   exp_next_pc;
    logic    exp_stop;

    word_t       prog_main [$];
    word_t       prog_illegal [$];
    logic [31:0] rng;
    int          cycles;
    int          cycle_limit;

    proc #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) proc_i (
        .clk(clk), .rst_n(rst_n),
        .imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
        .retire(retire), .err(err)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("Done: errors found");
        $fatal(1, "check failed");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t sign_extend(input word_t v, input int bits);
        word_t t;
        t = v << (16 - bits);
        return word_t'($signed(t) >>> (16 - bits));
    endfunction

    ////////////////////////////////////////////////////////////
    // programs
    ////////////////////////////////////////////////////////////
    task automatic build_main_program();
        opcode_t     alu_ops [4] = '{OP_ADD, OP_SUB, OP_AND, OP_XOR};
        logic [31:0] r;
        int          kind;
        int          halt_pos;
        reg_idx_t    dst;
        reg_idx_t    src1;
        reg_idx_t    src2;
        // r7 is the load/store base, never written after this
        prog_main.push_back(asm_lbi(3'd7, 8'd64));
        prog_main.push_back(asm_lbi(3'd1, 8'hfd));
        prog_main.push_back(asm_lbi(3'd2, 8'h7f));
        prog_main.push_back(asm_rtype(OP_ADD, 3'd3, 3'd1, 3'd2));
        prog_main.push_back(asm_rtype(OP_SUB, 3'd4, 3'd1, 3'd2));
        prog_main.push_back(asm_rtype(OP_AND, 3'd5, 3'd1, 3'd2));
        prog_main.push_back(asm_rtype(OP_XOR, 3'd6, 3'd1, 3'd2));
        prog_main.push_back(asm_addi(3'd3, 3'd3, 5'h10));
        prog_main.push_back(asm_st(3'd2, 3'd7, 5'd5));
        prog_main.push_back(asm_ld(3'd4, 3'd7, 5'd5));
        // count-down loop with a backward bnez
        prog_main.push_back(asm_lbi(3'd1, 8'd3));
        prog_main.push_back(asm_addi(3'd1, 3'd1, 5'h1f));
        prog_main.push_back(asm_branch(1'b0, 3'd1, 8'hfe));
        prog_main.push_back(asm_branch(1'b1, 3'd1, 8'd1));
        prog_main.push_back(asm_lbi(3'd6, 8'd1));
        prog_main.push_back(asm_j(11'd1));
        prog_main.push_back(asm_lbi(3'd6, 8'd2));
        prog_main.push_back(asm_branch(1'b1, 3'd2, 8'd3));
        // 0xff80 + 0xff80 wraps
        prog_main.push_back(asm_lbi(3'd5, 8'h80));
        prog_main.push_back(asm_rtype(OP_ADD, 3'd5, 3'd5, 3'd5));
        prog_main.push_back(asm_st(3'd5, 3'd7, 5'h1b));
        prog_main.push_back(asm_ld(3'd0, 3'd7, 5'h1b));
        halt_pos = prog_main.size() + RAND_LEN;
        for (int i = 0; i < RAND_LEN; i++) begin
            rng  = xorshift32(rng);
            r    = rng;
            kind = int'(r[3:0]) % 9;
            dst  = reg_idx_t'(int'(r[6:4]) % 7);
            src1 = r[9:7];
            src2 = r[12:10];
            case (kind)
                0, 1, 2, 3: prog_main.push_back(asm_rtype(alu_ops[kind], dst, src1, src2));
                4: prog_main.push_back(asm_addi(dst, src1, r[17:13]));
                5: prog_main.push_back(asm_lbi(dst, r[25:18]));
                6: prog_main.push_back(asm_ld(dst, 3'd7, r[17:13]));
                7: prog_main.push_back(asm_st(src2, 3'd7, r[17:13]));
                default: begin
                    // forward only, never past the halt
                    if (prog_main.size() + 1 + int'(r[27:26]) <= halt_pos) begin
                        prog_main.push_back(asm_branch(r[28], src1, {6'd0, r[27:26]}));
                    end else begin
                        prog_main.push_back(asm_addi(dst, src1, r[17:13]));
                    end
                end
            endcase
        end
        prog_main.push_back(asm_halt());
    endtask

    task automatic build_illegal_program();
        prog_illegal.push_back(asm_lbi(3'd1, 8'd5));
        prog_illegal.push_back(asm_addi(3'd2, 3'd1, 5'd3));
        prog_illegal.push_back(asm_st(3'd2, 3'd7, 5'd2));
        prog_illegal.push_back(asm_undef());
        prog_illegal.push_back(asm_lbi(3'd3, 8'd9));
        prog_illegal.push_back(asm_halt());
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////
    task automatic reset_model();
        foreach (m_regs[i]) m_regs[i] = '0;
        foreach (m_dmem[i]) m_dmem[i] = '0;
        m_pc     = '0;
        m_halted = 1'b0;
        m_err    = 1'b0;
    endtask

    task automatic predict_retire();
        word_t      instr;
        logic [4:0] op;
        word_t      a;
        word_t      b;
        word_t      imm5;
        word_t      imm8;
        instr = m_imem[int'(m_pc) % IMEM_DEPTH];
        op    = instr[15:11];
        a     = m_regs[instr[10:8]];
        b     = m_regs[instr[7:5]];
        imm5  = sign_extend(word_t'(instr[4:0]), 5);
        imm8  = sign_extend(word_t'(instr[7:0]), 8);
        exp         = '0;
        exp.valid   = 1'b1;
        exp.pc      = m_pc;
        exp_next_pc = m_pc + 16'd1;
        exp_stop    = 1'b0;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
                exp.reg_we = 1'b1;
                exp.wr_reg = instr[4:2];
                case (op)
                    OP_ADD:  exp.wr_data = a + b;
                    OP_SUB:  exp.wr_data = a - b;
                    OP_AND:  exp.wr_data = a & b;
                    default: exp.wr_data = a ^ b;
                endcase
            end
            OP_ADDI: begin
                exp.reg_we  = 1'b1;
                exp.wr_reg  = instr[7:5];
                exp.wr_data = a + imm5;
            end
            OP_LBI: begin
                exp.reg_we  = 1'b1;
                exp.wr_reg  = instr[10:8];
                exp.wr_data = imm8;
            end
            OP_LD: begin
                exp.reg_we  = 1'b1;
                exp.wr_reg  = instr[7:5];
                exp.wr_data = m_dmem[int'(a + imm5) % DMEM_DEPTH];
            end
            OP_ST: begin
                exp.mem_we    = 1'b1;
                exp.mem_addr  = a + imm5;
                exp.mem_wdata = b;
            end
            OP_BEQZ: if (a == '0) exp_next_pc = m_pc + 16'd1 + imm8;
            OP_BNEZ: if (a != '0) exp_next_pc = m_pc + 16'd1 + imm8;
            OP_J: exp_next_pc = m_pc + 16'd1 + sign_extend(word_t'(instr[10:0]), 11);
            OP_HALT: exp_stop = 1'b1;
            default: begin
                exp_stop = 1'b1;
                m_err    = 1'b1;
            end
        endcase
    endtask

    task automatic commit_retire();
        if (exp.reg_we) m_regs[exp.wr_reg] = exp.wr_data;
        if (exp.mem_we) m_dmem[int'(exp.mem_addr) % DMEM_DEPTH] = exp.mem_wdata;
        m_pc = exp_next_pc;
        if (exp_stop) m_halted = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////
    // checks, sampled mid-cycle
    ////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (!rst_n) begin
            assert (!retire.valid && !err) else report_error("valid or err high in reset");
        end else if (!m_halted) begin
            predict_retire();
            assert (retire.valid) else report_error("no retirement while running");
            assert (retire.pc == exp.pc)
                else report_error($sformatf("pc %h, expected %h", retire.pc, exp.pc));
            assert (retire.reg_we == exp.reg_we)
                else report_error($sformatf("reg_we %b at pc %h", retire.reg_we, exp.pc));
            if (exp.reg_we) begin
                assert (retire.wr_reg == exp.wr_reg)
                    else report_error($sformatf("wr_reg %0d, expected %0d",
                                                retire.wr_reg, exp.wr_reg));
                assert (retire.wr_data == exp.wr_data)
                    else report_error($sformatf("wr_data %h, expected %h",
                                                retire.wr_data, exp.wr_data));
            end
            assert (retire.mem_we == exp.mem_we)
                else report_error($sformatf("mem_we %b at pc %h", retire.mem_we, exp.pc));
            if (exp.mem_we) begin
                assert (retire.mem_addr == exp.mem_addr)
                    else report_error($sformatf("mem_addr %h, expected %h",
                                                retire.mem_addr, exp.mem_addr));
                assert (retire.mem_wdata == exp.mem_wdata)
                    else report_error($sformatf("mem_wdata %h, expected %h",
                                                retire.mem_wdata, exp.mem_wdata));
            end
            assert (err == m_err) else report_error($sformatf("err %b, expected %b", err, m_err));
            commit_retire();
        end else begin
            assert (!retire.valid && !retire.reg_we && !retire.mem_we)
                else report_error("retirement or write after the core stopped");
            assert (err == m_err) else report_error($sformatf("err %b, expected %b", err, m_err));
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Done: errors found");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////
    // reset, load under reset, run until the model sees the core stop
    task automatic run_program(input word_t code [$]);
        @(posedge clk);
        rst_n <= 1'b0;
        reset_model();
        foreach (code[i]) begin
            @(posedge clk);
            imem_we   <= 1'b1;
            imem_addr <= word_t'(i);
            imem_data <= code[i];
            m_imem[i] = code[i];
        end
        @(posedge clk);
        imem_we <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        while (!m_halted) @(negedge clk);
        repeat (DRAIN_CYCLES) @(negedge clk);
    endtask

    initial begin
        rst_n     <= 1'b0;
        imem_we   <= 1'b0;
        imem_addr <= '0;
        imem_data <= '0;
        rng = SEED;
        build_main_program();
        build_illegal_program();
        cycle_limit = 4 * (prog_main.size() + prog_illegal.size()) + 100;
        run_program(prog_main);
        run_program(prog_illegal);
        $display("Done: no errors");
        $finish;
    end

endmodule

/* files.f */
+incdir+include
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/fetch.sv
hdl/reg_file.sv
hdl/decode.sv
hdl/execute.sv
hdl/memory.sv
hdl/proc.sv
verif/proc_tb.sv
